// File: rtl/capture_buffer.sv
// capture RAM with a stream write port and a bus read port
// samples packed two per word, first sample in the low half
// write side stops by back-pressure once 512 samples are stored

`timescale 1ns/1ps
`include "capture_config.svh"

module capture_buffer (
  input  logic                     bus,
  input  logic                     ctl_rst,
  // stream input
  input  capture_pkg::str_t        str_in,
  output logic                     str_ready,
  // bus read port, reads only
  input  capture_pkg::bus_req_t    req,
  output capture_pkg::bus_rsp_t    rsp,
  // control from the register block
  input  logic                     arm,
  input  logic                     clear,
  output capture_pkg::sample_cnt_t count
);

localparam int unsigned DEPTH = 2**`CAP_BUF_AW;
localparam int unsigned SW    = `CAP_SAMPLE_W;

//////////////////////////////
// local signals
//////////////////////////////

// RAM, one bus word per entry
capture_pkg::word_t    buf_mem [0:DEPTH-1];

// write side
capture_pkg::buf_ptr_t wptr;
logic                  full;
logic                  transfer;
logic [`CAP_BUF_AW-1:0] waddr;
logic                  lane;

// read side
capture_pkg::bus_addr_t offset;
logic [`CAP_BUF_AW-1:0] raddr;
logic                   ren_q;
logic                   ack_q;
capture_pkg::word_t     rdata_q;

// unwritten words read back as zero
initial begin
  for (int i = 0; i < DEPTH; i++) begin
    buf_mem[i] = '0;
  end
end

//////////////////////////////
// stream write
//////////////////////////////

// hold off during clear so no beat is taken and then lost
assign str_ready = arm & ~full & ~clear;
assign transfer  = str_in.valid & str_ready;

// upper pointer bits pick the word, bit 0 the lane
assign waddr = wptr[`CAP_BUF_AW:1];
assign lane  = wptr[0];

// pointer and full flag, clear wins over a transfer
always_ff @(posedge bus) begin
  if (ctl_rst) begin
    wptr <= '0;
    full <= 1'b0;
  end else if (clear) begin
    wptr <= '0;
    full <= 1'b0;
  end else if (transfer) begin
    wptr <= wptr + 1'b1;
    // last slot taken, pointer wraps to zero
    if (&wptr) begin
      full <= 1'b1;
    end
  end
end

// halfword lane write
always_ff @(posedge bus) begin
  if (transfer) begin
    if (lane) begin
      buf_mem[waddr][2*SW-1:SW] <= str_in.data;
    end else begin
      buf_mem[waddr][SW-1:0] <= str_in.data;
    end
  end
end

// full flag is the msb once the pointer has wrapped
assign count = {full, wptr};

//////////////////////////////
// bus read
//////////////////////////////

// word n sits at base plus 4n
assign offset = req.addr - capture_pkg::bus_addr_t'(`CAP_BUF_BASE);

// stage 1 latches the address, stage 2 reads the RAM
always_ff @(posedge bus) begin
  if (req.ren) begin
    raddr <= offset[`CAP_BUF_AW+1:2];
  end
  if (ren_q) begin
    rdata_q <= buf_mem[raddr];
  end
end

// ack two cycles after the request
always_ff @(posedge bus) begin
  if (ctl_rst) begin
    ren_q <= 1'b0;
    ack_q <= 1'b0;
  end else begin
    ren_q <= req.ren;
    ack_q <= ren_q;
  end
end

assign rsp.ack   = ack_q;
assign rsp.err   = 1'b0;
assign rsp.rdata = rdata_q;

endmodule

// File: rtl/capture_config.svh
// widths and register map of the sample capture buffer
// include in the package and in every module that decodes addresses

`ifndef CAPTURE_CONFIG_SVH
`define CAPTURE_CONFIG_SVH

// stream sample width, two samples per bus word
`define CAP_SAMPLE_W 16
`define CAP_WORD_W (2*`CAP_SAMPLE_W)

// buffer word address width, 256 words or 512 samples
`define CAP_BUF_AW 8

// system bus byte address width
`define CAP_BUS_AW 16

// register map
`define CAP_REG_CTRL   16'h0000
`define CAP_REG_STATUS 16'h0004
// buffer region is every address with this bit set
`define CAP_BUF_BASE   16'h8000

// field positions
`define CAP_CTRL_CLR_BIT    0
`define CAP_CTRL_ARM_BIT    1
`define CAP_STATUS_FULL_BIT 16

`endif

// File: rtl/capture_ctrl.sv
// control and status registers of the capture buffer
// CTRL holds the arm bit and fires the pointer-clear pulse
// STATUS reports the sample count and the full flag, read only

`timescale 1ns/1ps
`include "capture_config.svh"

module capture_ctrl (
  input  logic                     bus,
  input  logic                     ctl_rst,
  // bus slave port, strobes only for CTRL and STATUS
  input  capture_pkg::bus_req_t    req,
  output capture_pkg::bus_rsp_t    rsp,
  // buffer side
  input  capture_pkg::sample_cnt_t count,
  output logic                     arm,
  output logic                     clear
);

// count of a full buffer
localparam int unsigned FULL_CNT = 2**(`CAP_BUF_AW+1);

//////////////////////////////
// local signals
//////////////////////////////

logic               hit_ctrl;
logic               hit_status;
logic               ctrl_wen;
logic               full;
capture_pkg::word_t rd_word;
capture_pkg::word_t rdata_q;
logic               ack_q;

// register decode
assign hit_ctrl   = req.addr == capture_pkg::bus_addr_t'(`CAP_REG_CTRL);
assign hit_status = req.addr == capture_pkg::bus_addr_t'(`CAP_REG_STATUS);
assign ctrl_wen   = req.wen & hit_ctrl;

assign full = count == capture_pkg::sample_cnt_t'(FULL_CNT);

//////////////////////////////
// CTRL write
//////////////////////////////

// clear is a one cycle pulse after the write
// STATUS writes fall through untouched
always_ff @(posedge bus) begin
  if (ctl_rst) begin
    arm   <= 1'b0;
    clear <= 1'b0;
  end else begin
    clear <= ctrl_wen & req.wdata[`CAP_CTRL_CLR_BIT];
    if (ctrl_wen) begin
      arm <= req.wdata[`CAP_CTRL_ARM_BIT];
    end
  end
end

//////////////////////////////
// read back
//////////////////////////////

// clear bit always reads 0
always_comb begin
  rd_word = '0;
  if (hit_ctrl) begin
    rd_word[`CAP_CTRL_ARM_BIT] = arm;
  end else if (hit_status) begin
    rd_word[`CAP_BUF_AW+1:0]      = count;
    rd_word[`CAP_STATUS_FULL_BIT] = full;
  end
end

// read data captured with the request
always_ff @(posedge bus) begin
  if (req.ren) begin
    rdata_q <= rd_word;
  end
end

// ack one cycle after any request
always_ff @(posedge bus) begin
  if (ctl_rst) begin
    ack_q <= 1'b0;
  end else begin
    ack_q <= req.wen | req.ren;
  end
end

assign rsp.ack   = ack_q;
assign rsp.err   = 1'b0;
assign rsp.rdata = rdata_q;

endmodule

// File: rtl/capture_pkg.sv
// shared types of the capture buffer
// bus request and response structs, stream beat and meaningful widths
// reference by scoped name, e.g. capture_pkg::bus_req_t

`include "capture_config.svh"

package capture_pkg;

//////////////////////////////
// plain vectors
//////////////////////////////

// one stream sample
typedef logic [`CAP_SAMPLE_W-1:0] sample_t;

// one bus data word, two samples
typedef logic [`CAP_WORD_W-1:0] word_t;

// byte address on the system bus
typedef logic [`CAP_BUS_AW-1:0] bus_addr_t;

// sample write pointer, word index plus halfword lane
typedef logic [`CAP_BUF_AW:0] buf_ptr_t;

// sample count, one bit wider so a full buffer fits
typedef logic [`CAP_BUF_AW+1:0] sample_cnt_t;

//////////////////////////////
// bus and stream structs
//////////////////////////////

// request strobes are single cycle, addr and wdata valid with them
typedef struct packed {
  logic      wen;
  logic      ren;
  bus_addr_t addr;
  word_t     wdata;
} bus_req_t;

// rdata and err only meaningful in the ack cycle
typedef struct packed {
  logic  ack;
  logic  err;
  word_t rdata;
} bus_rsp_t;

// ready travels back separately
typedef struct packed {
  logic    valid;
  sample_t data;
} str_t;

endpackage

// File: rtl/capture_top.sv
// top level of the sample capture buffer
// 16-bit stream in, system bus out for the registers and the RAM
// everything runs on the bus clock

`timescale 1ns/1ps

module capture_top (
  input  logic                  bus,
  input  logic                  ctl_rst,
  // sample stream
  input  capture_pkg::str_t     str_in,
  output logic                  str_ready,
  // system bus
  input  capture_pkg::bus_req_t bus_req,
  output capture_pkg::bus_rsp_t bus_rsp
);

//////////////////////////////
// local signals
//////////////////////////////

// decoded bus paths
capture_pkg::bus_req_t    reg_req;
capture_pkg::bus_rsp_t    reg_rsp;
capture_pkg::bus_req_t    buf_req;
capture_pkg::bus_rsp_t    buf_rsp;

// control between registers and buffer
logic                     arm;
logic                     clear;
capture_pkg::sample_cnt_t count;

// address decode
sys_bus_mux sys_bus_mux_i (
  .bus     (bus),
  .ctl_rst (ctl_rst),
  .bus_req (bus_req),
  .bus_rsp (bus_rsp),
  .reg_req (reg_req),
  .reg_rsp (reg_rsp),
  .buf_req (buf_req),
  .buf_rsp (buf_rsp)
);

// control and status
capture_ctrl capture_ctrl_i (
  .bus     (bus),
  .ctl_rst (ctl_rst),
  .req     (reg_req),
  .rsp     (reg_rsp),
  .count   (count),
  .arm     (arm),
  .clear   (clear)
);

// sample RAM
capture_buffer capture_buffer_i (
  .bus       (bus),
  .ctl_rst   (ctl_rst),
  .str_in    (str_in),
  .str_ready (str_ready),
  .req       (buf_req),
  .rsp       (buf_rsp),
  .arm       (arm),
  .clear     (clear),
  .count     (count)
);

endmodule

// File: rtl/sys_bus_mux.sv
// system bus decoder for the capture block
// routes requests to the register block or the buffer by address
// unmapped addresses and buffer writes get an error ack of its own

`timescale 1ns/1ps
`include "capture_config.svh"

module sys_bus_mux (
  input  logic                  bus,
  input  logic                  ctl_rst,
  // master side
  input  capture_pkg::bus_req_t bus_req,
  output capture_pkg::bus_rsp_t bus_rsp,
  // register block
  output capture_pkg::bus_req_t reg_req,
  input  capture_pkg::bus_rsp_t reg_rsp,
  // buffer
  output capture_pkg::bus_req_t buf_req,
  input  capture_pkg::bus_rsp_t buf_rsp
);

//////////////////////////////
// decode
//////////////////////////////

logic buf_hit;
logic reg_hit;
logic buf_rd;
logic bad;
logic err_q;

// buffer region is any address with the base bit set
assign buf_hit = |(bus_req.addr & capture_pkg::bus_addr_t'(`CAP_BUF_BASE));
assign reg_hit = ~buf_hit &
                 ((bus_req.addr == capture_pkg::bus_addr_t'(`CAP_REG_CTRL)) |
                  (bus_req.addr == capture_pkg::bus_addr_t'(`CAP_REG_STATUS)));

// buffer is read only
assign buf_rd = buf_hit & bus_req.ren & ~bus_req.wen;

// everything not claimed by a target
assign bad = (bus_req.wen | bus_req.ren) & ~reg_hit & ~buf_rd;

// per target strobes, addr and wdata shared
always_comb begin
  reg_req     = bus_req;
  reg_req.wen = bus_req.wen & reg_hit;
  reg_req.ren = bus_req.ren & reg_hit;
  buf_req     = bus_req;
  buf_req.wen = 1'b0;
  buf_req.ren = buf_rd;
end

//////////////////////////////
// error ack and response OR
//////////////////////////////

// error ack one cycle after the request
always_ff @(posedge bus) begin
  if (ctl_rst) begin
    err_q <= 1'b0;
  end else begin
    err_q <= bad;
  end
end

// at most one path acks, rdata masked by its own ack
assign bus_rsp.ack   = reg_rsp.ack | buf_rsp.ack | err_q;
assign bus_rsp.err   = reg_rsp.err | buf_rsp.err | err_q;
assign bus_rsp.rdata = ({`CAP_WORD_W{reg_rsp.ack}} & reg_rsp.rdata) |
                       ({`CAP_WORD_W{buf_rsp.ack}} & buf_rsp.rdata);

endmodule

// File: run.sh
#!/bin/sh
# build the capture testbench with Verilator and run it from the project root
# the log is searched for the failure message afterwards

rm -f sim.log
verilator --binary --timing --assert --top-module capture_tb -f vlog.f -o capture_sim \
  && ./obj_dir/capture_sim > sim.log 2>&1 \
  || { cat sim.log 2>/dev/null; echo "build or simulation error"; exit 1; }
cat sim.log
grep -q "Regression failed" sim.log && exit 1 || grep -q "Regression passed" sim.log || exit 1

// File: verification/capture_golden.txt
# columns: command then hex fields, W addr wdata err, R addr rdata err
# S count start, F count start transfers, T name begins a test
T reset_values
W 0004 ffffffff 0
R 0004 00000000 0
R 0000 00000000 0
F 0002 0000 0000
R 0010 00000000 1
W 8000 12345678 1
T arm_and_pack
W 0000 00000002 0
S 0006 1000
R 0004 00000006 0
R 8000 10011000 0
R 8008 10051004 0
T odd_count
S 0001 abcd
R 800c 0000abcd 0
R 0004 00000007 0
T clear
W 0000 00000003 0
R 0004 00000000 0
S 0002 0001
R 8000 00020001 0
T full_backpressure
W 0000 00000003 0
F 0208 0000 0200
R 0004 00010200 0
R 83fc 01ff01fe 0
T disarm
W 0000 00000003 0
S 0003 7000
W 0000 00000000 0
R 0000 00000000 0
F 0004 8000 0000
R 0004 00000003 0
R 8000 70017000 0

// File: verification/capture_sva.sv
// protocol checks on the capture buffer ports
// bound into capture_top, sees the internal arm level as well

`timescale 1ns/1ps

module capture_sva (
  input logic                  bus,
  input logic                  ctl_rst,
  input capture_pkg::bus_rsp_t bus_rsp,
  input logic                  str_ready,
  input logic                  arm
);

//////////////////////////////
// bus handshake
//////////////////////////////

// one ack per request, never two in a row
ack_single: assert property (@(posedge bus) disable iff (ctl_rst)
  bus_rsp.ack |=> !bus_rsp.ack)
  else $error("bus ack high in two consecutive cycles");

// err is only meaningful in the ack cycle
err_with_ack: assert property (@(posedge bus) disable iff (ctl_rst)
  bus_rsp.err |-> bus_rsp.ack)
  else $error("bus err without ack");

//////////////////////////////
// stream side
//////////////////////////////

// disarmed buffer takes no beats
ready_needs_arm: assert property (@(posedge bus) disable iff (ctl_rst)
  !arm |-> !str_ready)
  else $error("str_ready high while disarmed");

endmodule

// attach to every capture_top
bind capture_top capture_sva capture_sva_i (
  .bus       (bus),
  .ctl_rst   (ctl_rst),
  .bus_rsp   (bus_rsp),
  .str_ready (str_ready),
  .arm       (arm)
);

// File: verification/capture_tb.sv
// testbench for the sample capture buffer
// runs the commands of the golden file against capture_top, run from the project root

`timescale 1ns/1ps

module capture_tb;

// cycles to wait for a bus ack
localparam int ACK_LIMIT = 16;

logic                  bus = 1'b0;
logic                  ctl_rst;
capture_pkg::str_t     str_in;
logic                  str_ready;
capture_pkg::bus_req_t bus_req;
capture_pkg::bus_rsp_t bus_rsp;

integer           seed;
int               errors;
int               checks;
int               tests;
int               test_errors;
int               n_cmds;
logic [8*32-1:0]  test_name;

capture_top capture_top_i (
  .bus       (bus),
  .ctl_rst   (ctl_rst),
  .str_in    (str_in),
  .str_ready (str_ready),
  .bus_req   (bus_req),
  .bus_rsp   (bus_rsp)
);

// 100 ns period
always #50 bus = ~bus;

//////////////////////////////
// helpers
//////////////////////////////

task automatic count_error();
  errors++;
  test_errors++;
endtask

task automatic check_word(input string name, input capture_pkg::word_t exp,
                          input capture_pkg::word_t act);
  checks++;
  assert (act === exp) else begin
    $display("error at %0d ns: %s expected %08h got %08h", $time, name, exp, act);
    count_error();
  end
endtask

// first pass, number of bus and stream commands for the watchdog
task automatic count_commands(input int fd, output int n);
  logic [8*32-1:0]  tok;
  logic [8*256-1:0] rest;
  int               code;
  bit               done;
  n = 0;
  done = 1'b0;
  while (!done) begin
    code = $fscanf(fd, "%s", tok);
    if (code != 1) begin
      done = 1'b1;
    end else begin
      if (tok == "W" || tok == "R" || tok == "S" || tok == "F") begin
        n++;
      end
      code = $fgets(rest, fd);
    end
  end
endtask

// one request strobe, then wait for ack sampled mid cycle
task automatic bus_access(input logic wr, input capture_pkg::bus_addr_t addr,
                          input capture_pkg::word_t wdata,
                          output capture_pkg::word_t rdata, output logic err,
                          output logic acked);
  int waited;
  waited = 0;
  acked = 1'b0;
  rdata = '0;
  err = 1'b0;
  @(posedge bus);
  #1;
  bus_req.wen = wr;
  bus_req.ren = ~wr;
  bus_req.addr = addr;
  bus_req.wdata = wdata;
  @(posedge bus);
  #1;
  bus_req.wen = 1'b0;
  bus_req.ren = 1'b0;
  while (!acked && waited < ACK_LIMIT) begin
    @(negedge bus);
    if (bus_rsp.ack) begin
      acked = 1'b1;
      rdata = bus_rsp.rdata;
      err = bus_rsp.err;
    end
    waited++;
  end
endtask

// data is wdata for a write, expected rdata for a read
task automatic run_access(input logic wr, input capture_pkg::bus_addr_t addr,
                          input capture_pkg::word_t data, input logic exp_err);
  capture_pkg::word_t rdata;
  logic               err;
  logic               acked;
  bus_access(wr, addr, data, rdata, err, acked);
  checks++;
  assert (acked) else begin
    $display("no acknowledge for the access to %04h within %0d cycles", addr, ACK_LIMIT);
    count_error();
  end
  if (acked) begin
    check_word("bus_rsp.err", {31'b0, exp_err}, {31'b0, err});
    // error acks carry zero data
    if (!wr || exp_err) begin
      check_word("bus_rsp.rdata", wr ? 32'h0 : data, rdata);
    end
  end
endtask

// incrementing samples with random valid gaps
task automatic stream_samples(input int n, input capture_pkg::sample_t start,
                              input int exp_xfer, input bit refuse_rest);
  int sent;
  int cycles;
  bit busy;
  sent = 0;
  cycles = 0;
  busy = 1'b0;
  while (sent < exp_xfer && cycles < 8 * n + 64) begin
    @(posedge bus);
    #1;
    // a presented beat stays until taken
    if (!busy) begin
      busy = ($random(seed) & 3) != 0;
      str_in.valid = busy;
      str_in.data = start + capture_pkg::sample_t'(sent);
    end
    @(negedge bus);
    if (str_in.valid && str_ready) begin
      sent++;
      busy = 1'b0;
    end
    cycles++;
  end
  checks++;
  assert (sent == exp_xfer) else begin
    $display("stream stalled after %0d of %0d samples", sent, exp_xfer);
    count_error();
  end
  // leftover samples must be held off
  if (refuse_rest && n > exp_xfer) begin
    repeat (16) begin
      @(posedge bus);
      #1;
      str_in.valid = 1'b1;
      str_in.data = start + capture_pkg::sample_t'(sent);
      @(negedge bus);
      checks++;
      assert (!str_ready) else begin
        $display("error at %0d ns: str_ready expected 0 got 1", $time);
        count_error();
      end
    end
  end
  @(posedge bus);
  #1;
  str_in.valid = 1'b0;
endtask

task automatic close_test();
  if (tests > 0) begin
    if (test_errors == 0) begin
      $display("test %0s: ok", test_name);
    end else begin
      $display("test %0s: %0d errors", test_name, test_errors);
    end
  end
endtask

//////////////////////////////
// watchdog
//////////////////////////////

initial begin : watchdog
  wait (n_cmds > 0);
  #(n_cmds * 2000 * 100);
  $display("timeout, the run took longer than %0d commands allow", n_cmds);
  $display("Regression failed");
  $finish;
end

//////////////////////////////
// main sequence
//////////////////////////////

initial begin : main
  int               fd;
  int               code;
  bit               done;
  logic [8*32-1:0]  tok;
  logic [8*32-1:0]  name;
  logic [8*256-1:0] rest;
  logic [31:0]      f0;
  logic [31:0]      f1;
  logic [31:0]      f2;
  ctl_rst = 1'b1;
  bus_req = '0;
  str_in = '0;
  seed = 13;
  errors = 0;
  checks = 0;
  tests = 0;
  test_errors = 0;
  test_name = '0;
  n_cmds = 0;
  fd = $fopen("verification/capture_golden.txt", "r");
  if (fd == 0) begin
    $display("cannot open the golden file");
    count_error();
  end else begin
    count_commands(fd, n_cmds);
    $fclose(fd);
    fd = $fopen("verification/capture_golden.txt", "r");
  end
  // reset for two cycles
  repeat (2) @(posedge bus);
  #1;
  ctl_rst = 1'b0;
  done = (fd == 0);
  while (!done) begin
    code = $fscanf(fd, "%s", tok);
    if (code != 1) begin
      done = 1'b1;
    end else if (tok == "#") begin
      code = $fgets(rest, fd);
    end else if (tok == "T") begin
      code = $fscanf(fd, "%s", name);
      close_test();
      tests++;
      test_name = name;
      test_errors = 0;
    end else if (tok == "W" || tok == "R") begin
      code = $fscanf(fd, "%h %h %h", f0, f1, f2);
      run_access(tok == "W", f0[15:0], f1, f2[0]);
    end else if (tok == "S") begin
      code = $fscanf(fd, "%h %h", f0, f1);
      stream_samples(int'(f0), f1[15:0], int'(f0), 1'b0);
    end else if (tok == "F") begin
      code = $fscanf(fd, "%h %h %h", f0, f1, f2);
      stream_samples(int'(f0), f1[15:0], int'(f2), 1'b1);
    end else begin
      $display("unknown command %0s in the golden file", tok);
      count_error();
      done = 1'b1;
    end
  end
  close_test();
  $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
  if (errors == 0) begin
    $display("Regression passed");
  end else begin
    $display("Regression failed");
  end
  $finish;
end

endmodule

// File: vlog.f
+incdir+rtl
rtl/capture_pkg.sv
rtl/sys_bus_mux.sv
rtl/capture_ctrl.sv
rtl/capture_buffer.sv
rtl/capture_top.sv
verification/capture_sva.sv
verification/capture_tb.sv
